//--- hdl/axil_bus_pkg.sv
// Bus-side types for the 64-bit AXI4-Lite slave port
// Only OKAY is ever returned, and only address bits [4:3] select a register

package axil_bus_pkg;

	// ----------------------------------------
	// Channel widths
	// ----------------------------------------

	// Byte address, full AXI width even though most bits are ignored
	typedef logic [63:0] axil_addr_t;

	// One data beat, also the width of every timer register
	typedef logic [63:0] axil_data_t;

	// One strobe bit per data byte
	typedef logic [7:0] axil_strb_t;

	// Response code on B and R channels
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY = 2'b00;

	// ----------------------------------------
	// Register access
	// ----------------------------------------

	// Word index into the register map, from address bits [4:3]
	typedef logic [1:0] reg_idx_t;

	// Lowest address bit of the word index (8-byte words)
	localparam int unsigned REG_IDX_LSB = 3;

	// Write request from the bus FSM to the register file
	// Valid for exactly one cycle, in the cycle AWREADY/WREADY are high
	typedef struct packed {
		logic       en;
		reg_idx_t   idx;
		axil_data_t data;
		axil_strb_t strb;
	} reg_wr_t;

endpackage

//--- hdl/timer_regs_pkg.sv
// Register map and timer-side structs of the interval timer
// CTRL keeps two bits, STATUS keeps one sticky flag

package timer_regs_pkg;

	// ----------------------------------------
	// Register map
	// ----------------------------------------

	// Word indices, one 64-bit register each
	localparam axil_bus_pkg::reg_idx_t REG_CTRL   = 2'd0;
	localparam axil_bus_pkg::reg_idx_t REG_PERIOD = 2'd1;
	localparam axil_bus_pkg::reg_idx_t REG_COUNT  = 2'd2;
	localparam axil_bus_pkg::reg_idx_t REG_STATUS = 2'd3;

	// CTRL field positions, all other bits read as zero
	localparam int unsigned CTRL_WIDTH      = 2;
	localparam int unsigned CTRL_ENABLE_BIT = 0;
	localparam int unsigned CTRL_RELOAD_BIT = 1;

	// STATUS expired flag, cleared by writing 1 here
	localparam int unsigned STATUS_EXPIRED_BIT = 0;

	// ----------------------------------------
	// Register file to counter
	// ----------------------------------------

	// Levels from CTRL plus the restart pulse on any CTRL write
	typedef struct packed {
		logic enable;
		logic auto_reload;
		logic restart;
	} timer_ctrl_t;

	// ----------------------------------------
	// Counter to register file
	// ----------------------------------------

	// Live count and a one-cycle pulse on reaching PERIOD
	typedef struct packed {
		axil_bus_pkg::axil_data_t count;
		logic                     expire;
	} cnt_state_t;

endpackage

//--- hdl/axil_slave_fsm.sv
// AXI4-Lite channel FSM, one transaction at a time, writes win over reads
// AW and W must both be valid before a write is accepted; responses are always OKAY

`timescale 1ns/100ps

module axil_slave_fsm
(
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,

	input  axil_bus_pkg::axil_addr_t S_AXI_AWADDR,
	input  logic                     S_AXI_AWVALID,
	output logic                     S_AXI_AWREADY,

	input  axil_bus_pkg::axil_data_t S_AXI_WDATA,
	input  axil_bus_pkg::axil_strb_t S_AXI_WSTRB,
	input  logic                     S_AXI_WVALID,
	output logic                     S_AXI_WREADY,

	output axil_bus_pkg::axil_resp_t S_AXI_BRESP,
	output logic                     S_AXI_BVALID,
	input  logic                     S_AXI_BREADY,

	input  axil_bus_pkg::axil_addr_t S_AXI_ARADDR,
	input  logic                     S_AXI_ARVALID,
	output logic                     S_AXI_ARREADY,

	output axil_bus_pkg::axil_resp_t S_AXI_RRESP,
	output logic                     S_AXI_RVALID,
	input  logic                     S_AXI_RREADY,

	output axil_bus_pkg::reg_wr_t    reg_wr,
	output logic                     rd_en,
	output axil_bus_pkg::reg_idx_t   rd_idx
);

	import axil_bus_pkg::*;

	// One state per bus phase
	typedef enum logic [2:0] {
		IDLE,
		WR_ACCEPT,
		WR_RESP,
		RD_ACCEPT,
		RD_DATA
	} fsm_state_t;

	fsm_state_t state;
	fsm_state_t state_nxt;

	// Request captured at the idle decision
	reg_idx_t   wr_idx_q;
	axil_data_t wr_data_q;
	axil_strb_t wr_strb_q;
	reg_idx_t   rd_idx_q;

	// ----------------------------------------
	// Next state
	// ----------------------------------------

	always_comb
	begin
		state_nxt = state;
		unique case (state)
			IDLE:
			begin
				// Write needs both AW and W, and has priority
				if (S_AXI_AWVALID && S_AXI_WVALID)
					state_nxt = WR_ACCEPT;
				else if (S_AXI_ARVALID)
					state_nxt = RD_ACCEPT;
			end
			// Ready is high here for exactly one cycle
			WR_ACCEPT: state_nxt = WR_RESP;
			RD_ACCEPT: state_nxt = RD_DATA;
			// Hold the response until the master takes it
			WR_RESP:
			begin
				if (S_AXI_BREADY)
					state_nxt = IDLE;
			end
			RD_DATA:
			begin
				if (S_AXI_RREADY)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// ----------------------------------------
	// Request capture
	// ----------------------------------------

	// Payload only, loaded while idle and stable through the accept cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state == IDLE)
		begin
			wr_idx_q  <= S_AXI_AWADDR[REG_IDX_LSB +: $bits(reg_idx_t)];
			wr_data_q <= S_AXI_WDATA;
			wr_strb_q <= S_AXI_WSTRB;
			rd_idx_q  <= S_AXI_ARADDR[REG_IDX_LSB +: $bits(reg_idx_t)];
		end
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------

	// AW and W are taken together
	assign S_AXI_AWREADY = (state == WR_ACCEPT);
	assign S_AXI_WREADY  = (state == WR_ACCEPT);
	assign S_AXI_BVALID  = (state == WR_RESP);
	assign S_AXI_BRESP   = RESP_OKAY;

	assign S_AXI_ARREADY = (state == RD_ACCEPT);
	assign S_AXI_RVALID  = (state == RD_DATA);
	assign S_AXI_RRESP   = RESP_OKAY;

	// Register write fires in the accept cycle
	assign reg_wr.en   = (state == WR_ACCEPT);
	assign reg_wr.idx  = wr_idx_q;
	assign reg_wr.data = wr_data_q;
	assign reg_wr.strb = wr_strb_q;

	// Read data gets latched by the register file at the end of the accept cycle
	assign rd_en  = (state == RD_ACCEPT);
	assign rd_idx = rd_idx_q;

endmodule

//--- hdl/timer_reg_file.sv
// Timer registers: CTRL, PERIOD, read-only COUNT and write-1-clear STATUS
// Read data is registered on rd_en and held until the next read

`timescale 1ns/100ps

module timer_reg_file
(
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	input  axil_bus_pkg::reg_wr_t       reg_wr,
	input  logic                        rd_en,
	input  axil_bus_pkg::reg_idx_t      rd_idx,
	input  timer_regs_pkg::cnt_state_t  cnt,
	output axil_bus_pkg::axil_data_t    rdata,
	output axil_bus_pkg::axil_data_t    period,
	output timer_regs_pkg::timer_ctrl_t ctrl,
	output logic                        irq
);

	import axil_bus_pkg::*;
	import timer_regs_pkg::*;

	logic [CTRL_WIDTH-1:0] ctrl_q;
	axil_data_t            period_q;
	logic                  status_q;

	// Decoded write strobes per register
	logic       wr_ctrl;
	logic       wr_period;
	logic       status_clr;
	axil_data_t ctrl_merged;
	axil_data_t rd_mux;

	// Byte lanes with a strobe take the new data, the rest keep the old value
	function automatic axil_data_t strb_merge(input axil_data_t old_val,
		input axil_data_t new_val, input axil_strb_t strb);
		axil_data_t merged;
		merged = old_val;
		for (int i = 0; i < $bits(axil_strb_t); i++)
		begin
			if (strb[i])
				merged[i*8 +: 8] = new_val[i*8 +: 8];
		end
		return merged;
	endfunction

	// ----------------------------------------
	// Write side
	// ----------------------------------------

	assign wr_ctrl   = reg_wr.en && (reg_wr.idx == REG_CTRL);
	assign wr_period = reg_wr.en && (reg_wr.idx == REG_PERIOD);

	// Clear needs byte 0 strobed and the flag bit set
	assign status_clr = reg_wr.en && (reg_wr.idx == REG_STATUS) && reg_wr.strb[0]
		&& reg_wr.data[STATUS_EXPIRED_BIT];

	// CTRL merged as a full word, upper bits dropped on store
	assign ctrl_merged = strb_merge({{($bits(axil_data_t)-CTRL_WIDTH){1'b0}}, ctrl_q},
		reg_wr.data, reg_wr.strb);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			ctrl_q   <= '0;
			period_q <= '0;
			status_q <= 1'b0;
		end
		else
		begin
			if (wr_ctrl)
				ctrl_q <= ctrl_merged[CTRL_WIDTH-1:0];
			if (wr_period)
				period_q <= strb_merge(period_q, reg_wr.data, reg_wr.strb);
			// Expiry in the same cycle beats the clear
			if (cnt.expire)
				status_q <= 1'b1;
			else if (status_clr)
				status_q <= 1'b0;
		end
	end

	// ----------------------------------------
	// Read side
	// ----------------------------------------

	always_comb
	begin
		rd_mux = '0;
		unique case (rd_idx)
			REG_CTRL:   rd_mux[CTRL_WIDTH-1:0] = ctrl_q;
			REG_PERIOD: rd_mux = period_q;
			// Live count, not a stored copy
			REG_COUNT:  rd_mux = cnt.count;
			REG_STATUS: rd_mux[STATUS_EXPIRED_BIT] = status_q;
			default:    rd_mux = '0;
		endcase
	end

	// Held while RVALID waits for RREADY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_en)
			rdata <= rd_mux;
	end

	// ----------------------------------------
	// Timer side
	// ----------------------------------------

	assign ctrl.enable      = ctrl_q[CTRL_ENABLE_BIT];
	assign ctrl.auto_reload = ctrl_q[CTRL_RELOAD_BIT];
	// Any CTRL write restarts the count
	assign ctrl.restart     = wr_ctrl;

	assign period = period_q;
	assign irq    = status_q;

endmodule

//--- hdl/interval_counter.sv
// Prescaled up-counter, one tick every PRESCALE clocks while enabled
// PERIOD of 0 keeps it idle; without auto-reload it stops at PERIOD

`timescale 1ns/100ps

module interval_counter
#(
	parameter int PRESCALE = 4
)
(
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	input  timer_regs_pkg::timer_ctrl_t ctrl,
	input  axil_bus_pkg::axil_data_t    period,
	output timer_regs_pkg::cnt_state_t  cnt
);

	import axil_bus_pkg::*;

	// Divider width, at least one bit even for PRESCALE of 1
	localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRESCALE - 1);

	logic [PRE_W-1:0] pre_q;
	axil_data_t       cnt_q;
	axil_data_t       cnt_inc;
	logic             idle;
	logic             tick;
	logic             wrap;

	// Stopped when disabled, with no period, or parked at PERIOD in one-shot mode
	assign idle = !ctrl.enable || (period == '0) || (!ctrl.auto_reload && (cnt_q >= period));

	assign tick    = !idle && (pre_q == PRE_LAST);
	assign cnt_inc = cnt_q + 64'd1;
	// Also catches a PERIOD lowered below the running count
	assign wrap    = (cnt_inc >= period);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || ctrl.restart)
		begin
			pre_q <= '0;
			cnt_q <= '0;
		end
		else if (!idle)
		begin
			pre_q <= tick ? '0 : pre_q + 1'b1;
			if (tick)
			begin
				if (!wrap)
					cnt_q <= cnt_inc;
				else if (ctrl.auto_reload)
					cnt_q <= '0;
				else
					cnt_q <= period;
			end
		end
	end

	// Expire marks the tick that reaches PERIOD
	assign cnt.count  = cnt_q;
	assign cnt.expire = tick && wrap;

endmodule

//--- hdl/axil_timer_top.sv
// Interval timer behind a 64-bit AXI4-Lite slave, irq follows the STATUS flag
// AWPROT and ARPROT are accepted and ignored

`timescale 1ns/100ps

module axil_timer_top
#(
	parameter int PRESCALE = 4
)
(
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,

	input  axil_bus_pkg::axil_addr_t S_AXI_AWADDR,
	input  logic [2:0]               S_AXI_AWPROT,
	input  logic                     S_AXI_AWVALID,
	output logic                     S_AXI_AWREADY,

	input  axil_bus_pkg::axil_data_t S_AXI_WDATA,
	input  axil_bus_pkg::axil_strb_t S_AXI_WSTRB,
	input  logic                     S_AXI_WVALID,
	output logic                     S_AXI_WREADY,

	output axil_bus_pkg::axil_resp_t S_AXI_BRESP,
	output logic                     S_AXI_BVALID,
	input  logic                     S_AXI_BREADY,

	input  axil_bus_pkg::axil_addr_t S_AXI_ARADDR,
	input  logic [2:0]               S_AXI_ARPROT,
	input  logic                     S_AXI_ARVALID,
	output logic                     S_AXI_ARREADY,

	output axil_bus_pkg::axil_data_t S_AXI_RDATA,
	output axil_bus_pkg::axil_resp_t S_AXI_RRESP,
	output logic                     S_AXI_RVALID,
	input  logic                     S_AXI_RREADY,

	output logic                     irq
);

	import axil_bus_pkg::*;
	import timer_regs_pkg::*;

	// ----------------------------------------
	// Internal wiring
	// ----------------------------------------

	reg_wr_t     reg_wr;
	logic        rd_en;
	reg_idx_t    rd_idx;
	timer_ctrl_t ctrl;
	cnt_state_t  cnt;
	axil_data_t  period;

	// Bus protocol
	axil_slave_fsm u_fsm (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.reg_wr        (reg_wr),
		.rd_en         (rd_en),
		.rd_idx        (rd_idx)
	);

	// Register storage, read data goes straight out on R
	timer_reg_file u_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.reg_wr        (reg_wr),
		.rd_en         (rd_en),
		.rd_idx        (rd_idx),
		.cnt           (cnt),
		.rdata         (S_AXI_RDATA),
		.period        (period),
		.ctrl          (ctrl),
		.irq           (irq)
	);

	// Count engine
	interval_counter #(
		.PRESCALE (PRESCALE)
	) u_counter (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.ctrl          (ctrl),
		.period        (period),
		.cnt           (cnt)
	);

endmodule

//--- test/tb_axil_timer.sv
// Testbench for the AXI4-Lite interval timer with PRESCALE fixed at 4
// A reference model predicts register reads and a separate process compares R data

`timescale 1ns/100ps

module tb_axil_timer;

	import axil_bus_pkg::*;
	import timer_regs_pkg::*;

	localparam int PRESCALE    = 4;
	localparam int BUS_TIMEOUT = 50;
	localparam int IRQ_TIMEOUT = 1000;

	logic       S_AXI_ACLK;
	logic       S_AXI_ARESETN;
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic       wvalid;
	logic       wready;
	axil_resp_t bresp;
	logic       bvalid;
	logic       bready;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	axil_data_t rdata;
	axil_resp_t rresp;
	logic       rvalid;
	logic       rready;
	logic       irq;

	// Reference register model
	axil_data_t model_ctrl;
	axil_data_t model_period;
	axil_data_t model_count;
	logic       model_status;

	// Expected read words with one entry per issued read
	axil_data_t exp_q[$];
	bit         chk_q[$];
	axil_data_t exp_word;
	bit         exp_chk;

	logic [31:0] rng_state;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          test_errors_start;

	axil_timer_top #(
		.PRESCALE (PRESCALE)
	) u_dut (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (awaddr),
		.S_AXI_AWPROT  (3'b000),
		.S_AXI_AWVALID (awvalid),
		.S_AXI_AWREADY (awready),
		.S_AXI_WDATA   (wdata),
		.S_AXI_WSTRB   (wstrb),
		.S_AXI_WVALID  (wvalid),
		.S_AXI_WREADY  (wready),
		.S_AXI_BRESP   (bresp),
		.S_AXI_BVALID  (bvalid),
		.S_AXI_BREADY  (bready),
		.S_AXI_ARADDR  (araddr),
		.S_AXI_ARPROT  (3'b000),
		.S_AXI_ARVALID (arvalid),
		.S_AXI_ARREADY (arready),
		.S_AXI_RDATA   (rdata),
		.S_AXI_RRESP   (rresp),
		.S_AXI_RVALID  (rvalid),
		.S_AXI_RREADY  (rready),
		.irq           (irq)
	);

	// 100 ns clock
	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// ----------------------------------------
	// Helpers and reference model
	// ----------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Random upper bits around the word index in [4:3]
	function automatic axil_addr_t reg_addr(input reg_idx_t idx);
		return {next_rand(), 27'(next_rand()), idx, 3'd0};
	endfunction

	// Strobed byte lanes replace the old value
	function automatic axil_data_t byte_merge(input axil_data_t old_val,
		input axil_data_t new_val, input axil_strb_t strb);
		axil_data_t mask;
		for (int b = 0; b < 8; b++)
			mask[b*8 +: 8] = {8{strb[b]}};
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	// Expected read word per register
	function automatic axil_data_t expected_read(input reg_idx_t idx);
		case (idx)
			REG_CTRL:   return model_ctrl;
			REG_PERIOD: return model_period;
			REG_COUNT:  return model_count;
			default:    return {63'd0, model_status};
		endcase
	endfunction

	task automatic model_write(input reg_idx_t idx, input axil_data_t data,
		input axil_strb_t strb);
		case (idx)
			// CTRL keeps two bits and any write restarts the count
			REG_CTRL:
			begin
				model_ctrl  = byte_merge(model_ctrl, data, strb) & 64'h3;
				model_count = '0;
			end
			REG_PERIOD: model_period = byte_merge(model_period, data, strb);
			REG_STATUS:
			begin
				if (strb[0] && data[0])
					model_status = 1'b0;
			end
			default: ;
		endcase
	endtask

	task automatic compare_value(input string name, input axil_data_t exp_val,
		input axil_data_t act_val);
		checks++;
		if (act_val !== exp_val)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp_val, act_val);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors > test_errors_start)
		begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - test_errors_start);
		end
		else
			$display("test %0d %s: ok", tests_run, name);
		test_errors_start = errors;
	endtask

	// ----------------------------------------
	// Bus tasks
	// ----------------------------------------

	// Optional AR held alongside the write to probe for a second acceptance
	task automatic axil_write(input reg_idx_t idx, input axil_data_t data,
		input axil_strb_t strb, input int stall, input bit hold_ar);
		int n;
		@(posedge S_AXI_ACLK);
		awaddr  <= reg_addr(idx);
		wdata   <= data;
		wstrb   <= strb;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= (stall == 0);
		if (hold_ar)
		begin
			araddr  <= reg_addr(REG_PERIOD);
			arvalid <= 1'b1;
		end
		model_write(idx, data, strb);
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!awready && n < BUS_TIMEOUT);
		if (!awready || !wready)
		begin
			$display("write to register %0d was not accepted in time", idx);
			errors++;
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!bvalid && n < BUS_TIMEOUT);
		if (!bvalid)
		begin
			$display("no write response for register %0d in time", idx);
			errors++;
		end
		else
		begin
			compare_value("BRESP", RESP_OKAY, bresp);
			for (int i = 0; i < stall; i++)
			begin
				@(posedge S_AXI_ACLK);
				if (!bvalid)
				begin
					$display("BVALID dropped before BREADY was raised");
					errors++;
				end
				if (awready || arready)
				begin
					$display("new transaction accepted while a write response waits");
					errors++;
				end
			end
			if (stall > 0)
			begin
				bready <= 1'b1;
				@(posedge S_AXI_ACLK);
			end
		end
		bready <= 1'b0;
	endtask

	// With hold_ar the AR request stays up as the next read of the same register
	task automatic axil_read(input reg_idx_t idx, input int stall, input bit check_en,
		input bit hold_ar, output axil_data_t data);
		int         n;
		axil_data_t held;
		exp_q.push_back(expected_read(idx));
		chk_q.push_back(check_en);
		data = 'x;
		@(posedge S_AXI_ACLK);
		araddr  <= reg_addr(idx);
		arvalid <= 1'b1;
		rready  <= (stall == 0);
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!arready && n < BUS_TIMEOUT);
		if (!arready)
		begin
			$display("read of register %0d was not accepted in time", idx);
			errors++;
		end
		arvalid <= hold_ar;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!rvalid && n < BUS_TIMEOUT);
		if (!rvalid)
		begin
			$display("no read data for register %0d in time", idx);
			errors++;
		end
		else
		begin
			held = rdata;
			for (int i = 0; i < stall; i++)
			begin
				@(posedge S_AXI_ACLK);
				if (!rvalid)
				begin
					$display("RVALID dropped before RREADY was raised");
					errors++;
				end
				compare_value("RDATA held", held, rdata);
				if (awready || arready)
				begin
					$display("new transaction accepted while read data waits");
					errors++;
				end
			end
			if (stall > 0)
			begin
				rready <= 1'b1;
				@(posedge S_AXI_ACLK);
			end
			data = rdata;
		end
		rready <= 1'b0;
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		while (irq !== level && n < limit)
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		if (irq !== level)
		begin
			$display("irq did not reach %0b within %0d cycles", level, limit);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Read data comparison
	// ----------------------------------------

	// Each accepted R beat pops the expectation pushed when the read was issued
	always @(posedge S_AXI_ACLK)
	begin
		if (rvalid && rready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("read data arrived with no read outstanding");
				errors++;
			end
			else
			begin
				exp_word = exp_q.pop_front();
				exp_chk  = chk_q.pop_front();
				if (exp_chk)
					compare_value("RDATA", exp_word, rdata);
				compare_value("RRESP", RESP_OKAY, rresp);
			end
		end
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial
	begin
		axil_data_t rd;
		axil_data_t data;
		reg_idx_t   idx;
		int         stall;
		bit         irq_seen;

		S_AXI_ARESETN = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		rng_state    = 32'h292a_cbc5;
		model_ctrl   = '0;
		model_period = '0;
		model_count  = '0;
		model_status = 1'b0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errors_start = 0;

		repeat (3) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		@(posedge S_AXI_ACLK);

		// Reset values
		compare_value("irq", 64'(0), 64'(irq));
		compare_value("BVALID", 64'(0), 64'(bvalid));
		compare_value("RVALID", 64'(0), 64'(rvalid));
		compare_value("BRESP", RESP_OKAY, bresp);
		for (int i = 0; i < 4; i++)
			axil_read(reg_idx_t'(i), 0, 1'b1, 1'b0, rd);
		end_test("reset values");

		// Strobed writes to CTRL and PERIOD with enable kept clear
		for (int i = 0; i < 12; i++)
		begin
			idx  = next_rand() & 1 ? REG_PERIOD : REG_CTRL;
			data = {next_rand(), next_rand()};
			if (idx == REG_CTRL)
				data[0] = 1'b0;
			axil_write(idx, data, 8'(next_rand()), 0, 1'b0);
			axil_read(idx, 0, 1'b1, 1'b0, rd);
		end
		end_test("strobed register writes");

		// COUNT is read-only and STATUS clears only on a strobed 1
		axil_write(REG_COUNT, {next_rand(), next_rand()}, 8'hff, 0, 1'b0);
		axil_read(REG_COUNT, 0, 1'b1, 1'b0, rd);
		axil_write(REG_PERIOD, 64'd2, 8'hff, 0, 1'b0);
		axil_write(REG_CTRL, 64'h1, 8'hff, 0, 1'b0);
		wait_irq(1'b1, IRQ_TIMEOUT);
		model_status = 1'b1;
		model_count  = 64'd2;
		axil_write(REG_STATUS, 64'd0, 8'hff, 0, 1'b0);
		axil_read(REG_STATUS, 0, 1'b1, 1'b0, rd);
		// Flag bit set but byte 0 not strobed
		axil_write(REG_STATUS, 64'd1, 8'hfe, 0, 1'b0);
		axil_read(REG_STATUS, 0, 1'b1, 1'b0, rd);
		axil_write(REG_STATUS, 64'd1, 8'h01, 0, 1'b0);
		axil_read(REG_STATUS, 0, 1'b1, 1'b0, rd);
		axil_write(REG_CTRL, 64'h0, 8'hff, 0, 1'b0);
		axil_read(REG_COUNT, 0, 1'b1, 1'b0, rd);
		end_test("read-only count and status clear");

		// One-shot expiry holds at PERIOD
		axil_write(REG_PERIOD, 64'd20, 8'hff, 0, 1'b0);
		axil_write(REG_CTRL, 64'h1, 8'hff, 0, 1'b0);
		wait_irq(1'b1, IRQ_TIMEOUT);
		model_status = 1'b1;
		model_count  = 64'd20;
		for (int i = 0; i < 3; i++)
			axil_read(REG_COUNT, 0, 1'b1, 1'b0, rd);
		axil_read(REG_STATUS, 0, 1'b1, 1'b0, rd);
		axil_write(REG_STATUS, 64'd1, 8'h01, 0, 1'b0);
		compare_value("irq", 64'(0), 64'(irq));
		irq_seen = 1'b0;
		for (int i = 0; i < 200; i++)
		begin
			@(posedge S_AXI_ACLK);
			if (irq)
				irq_seen = 1'b1;
		end
		if (irq_seen)
		begin
			$display("irq rose again after a one-shot expiry was cleared");
			errors++;
		end
		end_test("one-shot expiry");

		// Auto-reload brings irq back after every clear
		axil_write(REG_CTRL, 64'h3, 8'hff, 0, 1'b0);
		for (int round = 0; round < 3; round++)
		begin
			wait_irq(1'b1, IRQ_TIMEOUT);
			model_status = 1'b1;
			for (int i = 0; i < 2; i++)
			begin
				axil_read(REG_COUNT, 0, 1'b0, 1'b0, rd);
				if (rd > model_period)
				begin
					$display("MISMATCH COUNT above PERIOD %h actual %h", model_period, rd);
					errors++;
				end
			end
			axil_write(REG_STATUS, 64'd1, 8'h01, 0, 1'b0);
			compare_value("irq", 64'(0), 64'(irq));
		end
		axil_write(REG_CTRL, 64'h0, 8'hff, 0, 1'b0);
		axil_write(REG_STATUS, 64'd1, 8'h01, 0, 1'b0);
		axil_read(REG_STATUS, 0, 1'b1, 1'b0, rd);
		axil_read(REG_COUNT, 0, 1'b1, 1'b0, rd);
		end_test("auto-reload");

		// Stalled responses with a request waiting behind each one
		for (int i = 0; i < 6; i++)
		begin
			stall = 1 + (next_rand() % 8);
			axil_write(REG_PERIOD, {next_rand(), next_rand()}, 8'(next_rand()), stall, 1'b1);
			stall = 1 + (next_rand() % 8);
			axil_read(REG_PERIOD, stall, 1'b1, 1'b1, rd);
			stall = 1 + (next_rand() % 8);
			axil_read(REG_PERIOD, stall, 1'b1, 1'b0, rd);
		end
		end_test("response back-pressure");

		repeat (2) @(posedge S_AXI_ACLK);
		if (exp_q.size() != 0)
		begin
			$display("%0d read responses never arrived", exp_q.size());
			errors++;
		end
		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verilog.f
hdl/axil_bus_pkg.sv
hdl/timer_regs_pkg.sv
hdl/axil_slave_fsm.sv
hdl/timer_reg_file.sv
hdl/interval_counter.sv
hdl/axil_timer_top.sv
test/tb_axil_timer.sv

//--- Bender.yml
package:
  name: axil_timer

sources:
  # Packages first, the RTL modules import them
  - hdl/axil_bus_pkg.sv
  - hdl/timer_regs_pkg.sv
  - hdl/axil_slave_fsm.sv
  - hdl/timer_reg_file.sv
  - hdl/interval_counter.sv
  - hdl/axil_timer_top.sv

  - target: test
    files:
      - test/tb_axil_timer.sv
